/* Makefile */
SIM     := verilator
TOP     := br_rs_tb
FLIST   := flist.f
FLAGS   := --binary --timing --assert -Wno-fatal
OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
hdl/br_rs_pkg.sv
hdl/result_bus_if.sv
hdl/wakeup_match.sv
hdl/operand_capture.sv
hdl/rs_entry_queue.sv
hdl/br_rs_top.sv
tests/br_rs_chk.sv
tests/br_rs_tb.sv

/* hdl/br_rs_pkg.sv */
package br_rs_pkg;

    localparam int XLEN        = 32;
    localparam int TAG_W       = 8;   // physical register tag
    localparam int INST_NUM_W  = 32;
    localparam int QUEUE_DEPTH = 16;  // power of two
    localparam int PTR_W       = $clog2(QUEUE_DEPTH);
    localparam int NUM_SRC     = 3;

    // index into the broadcast array, lowest index wins on a shared tag
    typedef enum logic [1:0] {
        SRC_ALU  = 2'd0,
        SRC_LOAD = 2'd1,
        SRC_LINK = 2'd2
    } result_src_e;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } br_cond_e;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  data;
    } result_bcast_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             ready;
        logic [XLEN-1:0]  data;
    } operand_t;

    typedef struct packed {
        logic [INST_NUM_W-1:0] inst_num;
        logic [XLEN-1:0]       pc;
        logic [TAG_W-1:0]      rd;
        logic                  jump;
        logic                  branch;
        br_cond_e              cond;
        logic [XLEN-1:0]       immediate;
        logic                  predicted_taken;
        logic                  btb_hit;
        operand_t              op1;
        operand_t              op2;
    } br_entry_t;

    typedef struct packed {
        logic [INST_NUM_W-1:0] inst_num;
        logic [XLEN-1:0]       pc;
        logic [TAG_W-1:0]      rd;
        logic                  jump;
        logic                  branch;
        br_cond_e              cond;
        logic [XLEN-1:0]       immediate;
        logic                  predicted_taken;
        logic                  btb_hit;
        logic [XLEN-1:0]       op1_data;
        logic [XLEN-1:0]       op2_data;
    } br_issue_t;

endpackage

/* hdl/br_rs_top.sv */
`timescale 1ns/1ps

module br_rs_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             flush,
    input  logic                             dispatch,
    input  logic [br_rs_pkg::INST_NUM_W-1:0] inst_num,
    input  logic [br_rs_pkg::XLEN-1:0]       pc,
    input  logic [br_rs_pkg::TAG_W-1:0]      rd,
    input  logic                             jump,
    input  logic                             branch,
    input  logic [2:0]                       funct3,
    input  logic [br_rs_pkg::XLEN-1:0]       immediate,
    input  logic                             predicted_taken,
    input  logic                             btb_hit,
    input  logic [br_rs_pkg::TAG_W-1:0]      op1_tag,
    input  logic [br_rs_pkg::TAG_W-1:0]      op2_tag,
    input  logic [br_rs_pkg::XLEN-1:0]       op1_data,
    input  logic [br_rs_pkg::XLEN-1:0]       op2_data,
    input  logic                             op1_ready,
    input  logic                             op2_ready,
    input  logic                             alu_valid,
    input  logic [br_rs_pkg::TAG_W-1:0]      alu_tag,
    input  logic [br_rs_pkg::XLEN-1:0]       alu_data,
    input  logic                             mem_read,
    input  logic [br_rs_pkg::TAG_W-1:0]      mem_tag,
    input  logic [br_rs_pkg::XLEN-1:0]       mem_data,
    input  logic                             link_done,
    input  logic [br_rs_pkg::TAG_W-1:0]      link_tag,
    input  logic [br_rs_pkg::XLEN-1:0]       link_data,
    output logic                             issue_valid,
    output logic [br_rs_pkg::INST_NUM_W-1:0] issue_inst_num,
    output logic [br_rs_pkg::XLEN-1:0]       issue_pc,
    output logic [br_rs_pkg::TAG_W-1:0]      issue_rd,
    output logic                             issue_jump,
    output logic                             issue_branch,
    output logic [2:0]                       issue_funct3,
    output logic [br_rs_pkg::XLEN-1:0]       issue_immediate,
    output logic                             issue_taken,
    output logic                             issue_hit,
    output logic [br_rs_pkg::XLEN-1:0]       issue_op1,
    output logic [br_rs_pkg::XLEN-1:0]       issue_op2,
    output logic                             queue_full
);
    import br_rs_pkg::*;

    br_entry_t dispatch_entry;
    br_entry_t captured_entry;
    logic      captured_dispatch;
    br_issue_t issue;

    result_bus_if i_bus ();

    assign i_bus.bcast[SRC_ALU]  = '{valid: alu_valid, tag: alu_tag, data: alu_data};
    assign i_bus.bcast[SRC_LOAD] = '{valid: mem_read, tag: mem_tag, data: mem_data};
    assign i_bus.bcast[SRC_LINK] = '{valid: link_done, tag: link_tag, data: link_data};

    assign dispatch_entry.inst_num        = inst_num;
    assign dispatch_entry.pc              = pc;
    assign dispatch_entry.rd              = rd;
    assign dispatch_entry.jump            = jump;
    assign dispatch_entry.branch          = branch;
    assign dispatch_entry.cond            = br_cond_e'(funct3);
    assign dispatch_entry.immediate       = immediate;
    assign dispatch_entry.predicted_taken = predicted_taken;
    assign dispatch_entry.btb_hit         = btb_hit;
    assign dispatch_entry.op1 = '{tag: op1_tag, ready: op1_ready, data: op1_data};
    assign dispatch_entry.op2 = '{tag: op2_tag, ready: op2_ready, data: op2_data};

    operand_capture i_capture (
        .dispatch     (dispatch),
        .dispatch_in  (dispatch_entry),
        .bus          (i_bus.sink),
        .entry_out    (captured_entry),
        .dispatch_out (captured_dispatch)
    );

    rs_entry_queue i_queue (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .dispatch    (captured_dispatch),
        .entry_in    (captured_entry),
        .bus         (i_bus.sink),
        .issue_valid (issue_valid),
        .issue       (issue),
        .queue_full  (queue_full)
    );

    assign issue_inst_num  = issue.inst_num;
    assign issue_pc        = issue.pc;
    assign issue_rd        = issue.rd;
    assign issue_jump      = issue.jump;
    assign issue_branch    = issue.branch;
    assign issue_funct3    = issue.cond;
    assign issue_immediate = issue.immediate;
    assign issue_taken     = issue.predicted_taken;
    assign issue_hit       = issue.btb_hit;
    assign issue_op1       = issue.op1_data;
    assign issue_op2       = issue.op2_data;

endmodule

/* hdl/operand_capture.sv */
`timescale 1ns/1ps

module operand_capture (
    input  logic                  dispatch,
    input  br_rs_pkg::br_entry_t  dispatch_in,
    result_bus_if.sink            bus,
    output br_rs_pkg::br_entry_t  entry_out,
    output logic                  dispatch_out
);
    import br_rs_pkg::*;

    logic            op1_hit;
    logic            op2_hit;
    logic [XLEN-1:0] op1_bypass;
    logic [XLEN-1:0] op2_bypass;

    wakeup_match i_op1_match (
        .tag  (dispatch_in.op1.tag),
        .bus  (bus),
        .hit  (op1_hit),
        .data (op1_bypass)
    );

    wakeup_match i_op2_match (
        .tag  (dispatch_in.op2.tag),
        .bus  (bus),
        .hit  (op2_hit),
        .data (op2_bypass)
    );

    // same-cycle bypass, each operand on its own
    always_comb begin
        entry_out = dispatch_in;
        if (!dispatch_in.op1.ready && op1_hit) begin
            entry_out.op1.ready = 1'b1;
            entry_out.op1.data  = op1_bypass;
        end
        if (!dispatch_in.op2.ready && op2_hit) begin
            entry_out.op2.ready = 1'b1;
            entry_out.op2.data  = op2_bypass;
        end
    end

    assign dispatch_out = dispatch;

endmodule

/* hdl/result_bus_if.sv */
`timescale 1ns/1ps

interface result_bus_if;
    import br_rs_pkg::*;

    // one slot per source, indexed by result_src_e
    result_bcast_t [NUM_SRC-1:0] bcast;

    modport source (
        output bcast
    );

    modport sink (
        input bcast
    );

endinterface

/* hdl/rs_entry_queue.sv */
`timescale 1ns/1ps

module rs_entry_queue (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 dispatch,
    input  br_rs_pkg::br_entry_t entry_in,
    result_bus_if.sink           bus,
    output logic                 issue_valid,
    output br_rs_pkg::br_issue_t issue,
    output logic                 queue_full
);
    import br_rs_pkg::*;

    br_entry_t              entries [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0] occupied;
    logic [PTR_W-1:0]       head;
    logic [PTR_W-1:0]       tail;
    logic [PTR_W:0]         count;
    logic [PTR_W:0]         count_next;

    logic [QUEUE_DEPTH-1:0] op1_hit;
    logic [QUEUE_DEPTH-1:0] op2_hit;
    logic [XLEN-1:0]        op1_wake [QUEUE_DEPTH];
    logic [XLEN-1:0]        op2_wake [QUEUE_DEPTH];

    br_entry_t head_entry;
    br_issue_t issue_next;
    logic      wr_en;
    logic      issue_fire;

    genvar g;
    generate
        for (g = 0; g < QUEUE_DEPTH; g++) begin : g_wakeup
            wakeup_match i_op1_match (
                .tag  (entries[g].op1.tag),
                .bus  (bus),
                .hit  (op1_hit[g]),
                .data (op1_wake[g])
            );

            wakeup_match i_op2_match (
                .tag  (entries[g].op2.tag),
                .bus  (bus),
                .hit  (op2_hit[g]),
                .data (op2_wake[g])
            );
        end
    endgenerate

    assign head_entry = entries[head];
    assign wr_en      = dispatch && !queue_full; // dropped when full
    assign issue_fire = occupied[head] && head_entry.op1.ready && head_entry.op2.ready;
    assign count_next = count + (PTR_W + 1)'(wr_en) - (PTR_W + 1)'(issue_fire);

    always_comb begin
        issue_next.inst_num        = head_entry.inst_num;
        issue_next.pc              = head_entry.pc;
        issue_next.rd              = head_entry.rd;
        issue_next.jump            = head_entry.jump;
        issue_next.branch          = head_entry.branch;
        issue_next.cond            = head_entry.cond;
        issue_next.immediate       = head_entry.immediate;
        issue_next.predicted_taken = head_entry.predicted_taken;
        issue_next.btb_hit         = head_entry.btb_hit;
        issue_next.op1_data        = head_entry.op1.data;
        issue_next.op2_data        = head_entry.op2.data;
    end

    // entry payload, wakeup and the tail write
    always_ff @(posedge clk) begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            if (occupied[i] && !entries[i].op1.ready && op1_hit[i]) begin
                entries[i].op1.ready <= 1'b1;
                entries[i].op1.data  <= op1_wake[i];
            end
            if (occupied[i] && !entries[i].op2.ready && op2_hit[i]) begin
                entries[i].op2.ready <= 1'b1;
                entries[i].op2.data  <= op2_wake[i];
            end
        end
        if (wr_en) begin
            entries[tail] <= entry_in; // tail slot is free here
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            occupied    <= '0;
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            queue_full  <= 1'b0;
            issue_valid <= 1'b0;
            issue       <= '0;
        end else begin
            if (wr_en) begin
                occupied[tail] <= 1'b1;
                tail           <= tail + 1'b1;
            end
            if (issue_fire) begin
                occupied[head] <= 1'b0;
                head           <= head + 1'b1; // wraps, depth is a power of two
            end
            count       <= count_next;
            queue_full  <= (count_next == (PTR_W + 1)'(QUEUE_DEPTH));
            issue_valid <= issue_fire;
            issue       <= issue_fire ? issue_next : '0;
        end
    end

endmodule

/* hdl/wakeup_match.sv */
`timescale 1ns/1ps

module wakeup_match (
    input  logic [br_rs_pkg::TAG_W-1:0] tag,
    result_bus_if.sink                  bus,
    output logic                        hit,
    output logic [br_rs_pkg::XLEN-1:0]  data
);
    import br_rs_pkg::*;

    logic [NUM_SRC-1:0] match;

    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            match[i] = bus.bcast[i].valid && (bus.bcast[i].tag == tag);
        end
    end

    // walk from the top so the lowest index ends up selected
    always_comb begin
        data = '0;
        for (int i = NUM_SRC - 1; i >= 0; i--) begin
            if (match[i]) begin
                data = bus.bcast[i].data;
            end
        end
    end

    assign hit = |match;

endmodule

/* tests/br_rs_chk.sv */
`timescale 1ns/1ps

module br_rs_chk (
    input logic                      clk,
    input logic                      reset,
    input logic                      flush,
    input logic                      dispatch,
    input logic                      queue_full,
    input logic                      issue_valid,
    input logic [br_rs_pkg::PTR_W:0] count
);
    import br_rs_pkg::*;

    // dispatcher must stall on a full queue
    no_dispatch_when_full: assert property (
        @(posedge clk) disable iff (reset) !(dispatch && queue_full)
    ) else $error("dispatch seen while queue_full is high");

    flush_clears_issue: assert property (
        @(posedge clk) disable iff (reset) flush |=> !issue_valid
    ) else $error("issue_valid high in the cycle after a flush");

    count_in_range: assert property (
        @(posedge clk) disable iff (reset) count <= (PTR_W + 1)'(QUEUE_DEPTH)
    ) else $error("occupancy count above queue depth");

endmodule

bind rs_entry_queue br_rs_chk i_chk (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .dispatch    (dispatch),
    .queue_full  (queue_full),
    .issue_valid (issue_valid),
    .count       (count)
);

/* tests/br_rs_tb.sv */
`timescale 1ns/1ps

module br_rs_tb;
    import br_rs_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_LIMIT  = 20; // cycles
    // reset, in-order, bypass, wakeup, fill and flush, plus room for each drain
    localparam int STIM_CYCLES  = RESET_CYCLES + 4 + 3 * 4 + 3 * 10 + 2 * QUEUE_DEPTH + 8
                                  + 4 * DRAIN_LIMIT;
    localparam int WATCHDOG_NS  = STIM_CYCLES * CLK_PERIOD + 200;

    logic          clk;
    logic          reset;
    logic          flush;
    logic          dispatch;
    br_entry_t     disp;
    result_bcast_t alu_bc;
    result_bcast_t mem_bc;
    result_bcast_t link_bc;

    logic                  issue_valid;
    logic                  issue_jump;
    logic                  issue_branch;
    logic                  issue_taken;
    logic                  issue_hit;
    logic                  queue_full;
    logic [2:0]            issue_funct3;
    logic [TAG_W-1:0]      issue_rd;
    logic [INST_NUM_W-1:0] issue_inst_num;
    logic [XLEN-1:0]       issue_pc;
    logic [XLEN-1:0]       issue_immediate;
    logic [XLEN-1:0]       issue_op1;
    logic [XLEN-1:0]       issue_op2;

    integer          seed;
    int              next_tag;
    int              next_inst;
    br_entry_t       dispatched [$];   // oldest unissued first
    logic [XLEN-1:0] bcast_data [256]; // broadcast log by tag
    br_cond_e        conds [6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};

    br_rs_top i_dut (
        .clk, .reset, .flush, .dispatch,
        .inst_num  (disp.inst_num),  .pc (disp.pc), .rd (disp.rd),
        .jump      (disp.jump),      .branch (disp.branch), .funct3 (disp.cond),
        .immediate (disp.immediate), .predicted_taken (disp.predicted_taken),
        .btb_hit   (disp.btb_hit),
        .op1_tag   (disp.op1.tag),   .op1_data (disp.op1.data), .op1_ready (disp.op1.ready),
        .op2_tag   (disp.op2.tag),   .op2_data (disp.op2.data), .op2_ready (disp.op2.ready),
        .alu_valid (alu_bc.valid),   .alu_tag (alu_bc.tag),   .alu_data (alu_bc.data),
        .mem_read  (mem_bc.valid),   .mem_tag (mem_bc.tag),   .mem_data (mem_bc.data),
        .link_done (link_bc.valid),  .link_tag (link_bc.tag), .link_data (link_bc.data),
        .issue_valid, .issue_inst_num, .issue_pc, .issue_rd, .issue_jump, .issue_branch,
        .issue_funct3, .issue_immediate, .issue_taken, .issue_hit, .issue_op1, .issue_op2,
        .queue_full
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch at %0d ns: %s expected %h, actual %h",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch at %0d ns: %s expected %b, actual %b",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_issue(input br_issue_t exp, input br_issue_t act);
        compare_field("issue_inst_num", exp.inst_num, act.inst_num);
        compare_field("issue_pc", exp.pc, act.pc);
        compare_field("issue_rd", exp.rd, act.rd);
        compare_field("issue_jump", exp.jump, act.jump);
        compare_field("issue_branch", exp.branch, act.branch);
        compare_field("issue_funct3", exp.cond, act.cond);
        compare_field("issue_immediate", exp.immediate, act.immediate);
        compare_field("issue_taken", exp.predicted_taken, act.predicted_taken);
        compare_field("issue_hit", exp.btb_hit, act.btb_hit);
        compare_field("issue_op1", exp.op1_data, act.op1_data);
        compare_field("issue_op2", exp.op2_data, act.op2_data);
    endtask

    // random payload, fresh tags so no two sources share one
    function automatic br_entry_t new_entry(input logic rdy1, input logic rdy2);
        br_entry_t e;
        e.inst_num        = next_inst;
        e.pc              = $random(seed);
        e.rd              = TAG_W'($random(seed));
        e.jump            = 1'($random(seed));
        e.branch          = !e.jump;
        e.cond            = conds[$unsigned($random(seed)) % 6];
        e.immediate       = $random(seed);
        e.predicted_taken = 1'($random(seed));
        e.btb_hit         = 1'($random(seed));
        e.op1 = '{tag: TAG_W'(next_tag), ready: rdy1, data: $random(seed)};
        e.op2 = '{tag: TAG_W'(next_tag + 1), ready: rdy2, data: $random(seed)};
        next_inst = next_inst + 1;
        next_tag  = next_tag + 2;
        return e;
    endfunction

    // dispatch fields pass through, operand data from dispatch or the broadcast log
    function automatic br_issue_t expected_issue(input br_entry_t rec);
        br_issue_t x;
        x.inst_num        = rec.inst_num;
        x.pc              = rec.pc;
        x.rd              = rec.rd;
        x.jump            = rec.jump;
        x.branch          = rec.branch;
        x.cond            = rec.cond;
        x.immediate       = rec.immediate;
        x.predicted_taken = rec.predicted_taken;
        x.btb_hit         = rec.btb_hit;
        x.op1_data        = rec.op1.ready ? rec.op1.data : bcast_data[rec.op1.tag];
        x.op2_data        = rec.op2.ready ? rec.op2.data : bcast_data[rec.op2.tag];
        return x;
    endfunction

    function automatic br_issue_t dut_issue();
        br_issue_t a;
        a.inst_num        = issue_inst_num;
        a.pc              = issue_pc;
        a.rd              = issue_rd;
        a.jump            = issue_jump;
        a.branch          = issue_branch;
        a.cond            = br_cond_e'(issue_funct3);
        a.immediate       = issue_immediate;
        a.predicted_taken = issue_taken;
        a.btb_hit         = issue_hit;
        a.op1_data        = issue_op1;
        a.op2_data        = issue_op2;
        return a;
    endfunction

    // strobes last one cycle
    task automatic tick();
        @(posedge clk);
        #1;
        dispatch      = 1'b0;
        flush         = 1'b0;
        alu_bc.valid  = 1'b0;
        mem_bc.valid  = 1'b0;
        link_bc.valid = 1'b0;
    endtask

    task automatic send(input br_entry_t e);
        disp     = e;
        dispatch = 1'b1;
        dispatched.push_back(e);
        tick();
    endtask

    task automatic set_bcast(input result_src_e src, input logic [TAG_W-1:0] t,
                             input logic [XLEN-1:0] d);
        case (src)
            SRC_ALU:  alu_bc  = '{valid: 1'b1, tag: t, data: d};
            SRC_LOAD: mem_bc  = '{valid: 1'b1, tag: t, data: d};
            default:  link_bc = '{valid: 1'b1, tag: t, data: d};
        endcase
        bcast_data[t] = d;
    endtask

    task automatic expect_valid(input logic exp);
        @(negedge clk);
        check_bit("issue_valid", exp, issue_valid);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (dispatched.size() != 0 && n < DRAIN_LIMIT) begin
            tick();
            n++;
        end
        if (dispatched.size() != 0) begin
            fail_run("dispatched entries never issued before the drain limit");
        end
    endtask

    // outputs settle by the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (!issue_valid) begin
                check_issue('0, dut_issue());
            end else if (dispatched.size() == 0) begin
                fail_run("issue_valid high with no dispatched entry outstanding");
            end else begin
                check_issue(expected_issue(dispatched.pop_front()), dut_issue());
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run($sformatf("timeout, test did not finish within %0d ns", WATCHDOG_NS));
    end

    initial begin
        br_entry_t   e;
        br_entry_t   young;
        result_src_e src;
        seed      = 92323;
        next_tag  = 1;
        next_inst = 1;
        clk       = 1'b0;
        reset     = 1'b1;
        flush     = 1'b0;
        dispatch  = 1'b0;
        disp      = '0;
        alu_bc    = '0;
        mem_bc    = '0;
        link_bc   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_bit("issue_valid", 1'b0, issue_valid);
        check_bit("queue_full", 1'b0, queue_full);
        tick();

        for (int i = 0; i < 4; i++) begin
            send(new_entry(1'b1, 1'b1));
        end
        wait_drain();

        // same-cycle bypass per source, last one on both operands
        for (int i = 0; i < NUM_SRC; i++) begin
            src = result_src_e'(i);
            e   = new_entry(i == 1, i == 0);
            if (!e.op1.ready) begin
                set_bcast(src, e.op1.tag, $random(seed));
            end
            if (!e.op2.ready) begin
                set_bcast((i == 2) ? SRC_ALU : src, e.op2.tag, $random(seed));
            end
            send(e);
            expect_valid(1'b0);
            expect_valid(1'b1);
            tick();
        end

        // waiting head, ready entry behind it
        for (int i = 0; i < NUM_SRC; i++) begin
            src   = result_src_e'(i);
            e     = new_entry(1'b0, 1'b1);
            young = new_entry(1'b1, 1'b1);
            send(e);
            send(young);
            expect_valid(1'b0);
            expect_valid(1'b0);
            tick();
            set_bcast(src, e.op1.tag, $random(seed));
            tick();
            expect_valid(1'b0);
            expect_valid(1'b1); // head
            expect_valid(1'b1); // then the younger one
            tick();
        end
        wait_drain();

        e = new_entry(1'b0, 1'b0);
        send(e);
        for (int i = 1; i < QUEUE_DEPTH; i++) begin
            send(new_entry(1'b1, 1'b1));
        end
        @(negedge clk);
        check_bit("queue_full", 1'b1, queue_full);
        tick();
        flush = 1'b1;
        tick();
        dispatched.delete();
        @(negedge clk);
        check_bit("queue_full", 1'b0, queue_full);
        tick();
        // operands of the flushed head show up late
        set_bcast(SRC_ALU, e.op1.tag, $random(seed));
        set_bcast(SRC_LOAD, e.op2.tag, $random(seed));
        tick();
        repeat (4) expect_valid(1'b0);
        tick();
        send(new_entry(1'b1, 1'b1));
        wait_drain();
        tick();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
